//--- euclid_settings.svh
//******************************
// Widths shared by the line core
// and its testbench. The delta
// width follows the wider axis
//******************************

`ifndef EUCLID_SETTINGS_SVH
`define EUCLID_SETTINGS_SVH

// Screen coordinate widths
`define EUCLID_X_W 10
`define EUCLID_Y_W 10

// Hue, saturation, intensity of 8 bits each
`define EUCLID_COLOR_W 24

// Unsigned delta, one bit wider than the wider axis
`define EUCLID_IDX_W ((`EUCLID_X_W > `EUCLID_Y_W) ? `EUCLID_X_W + 1 : `EUCLID_Y_W + 1)

`endif

//--- euclid_geom_pkg.sv
//******************************
// Geometry types of the line
// core. Error term is signed,
// one bit wider than a delta
//******************************

`include "euclid_settings.svh"

package euclid_geom_pkg;

  typedef logic [`EUCLID_X_W-1:0] pos_x_t;      // Pixel column
  typedef logic [`EUCLID_Y_W-1:0] pos_y_t;      // Pixel row

  // Absolute difference of two coordinates
  typedef logic [`EUCLID_IDX_W-1:0] delta_t;

  // Bresenham error, holds dx - dy at its widest
  typedef logic signed [`EUCLID_IDX_W:0] err_t;

  typedef logic [`EUCLID_COLOR_W-1:0] color_t;  // HSI word, not decoded here

endpackage

//--- euclid_ctrl_pkg.sv
//******************************
// Control types of the line
// core. Encoding is fixed
//******************************

package euclid_ctrl_pkg;

  localparam int LINE_STATE_W = 2;

  // Idle waits for a job, init loads the walker and the error term,
  // draw emits one pixel per transfer until the second point
  typedef enum logic [LINE_STATE_W-1:0] {
    LINE_IDLE = 2'd0,
    LINE_INIT = 2'd1,
    LINE_DRAW = 2'd2
  } line_state_t;

endpackage

//--- line_job_ctrl.sv
//******************************
// Job side of the line core.
// job_start counts only in idle,
// pulses while busy are dropped.
// End points and color are held
// for the whole job
//******************************

`include "euclid_settings.svh"

module line_job_ctrl (
  input  logic                          cr_intf,
  input  logic                          rst_n,
  input  logic                          job_start,
  input  euclid_geom_pkg::pos_x_t       x0,
  input  euclid_geom_pkg::pos_y_t       y0,
  input  euclid_geom_pkg::pos_x_t       x1,
  input  euclid_geom_pkg::pos_y_t       y1,
  input  euclid_geom_pkg::color_t       color,
  input  logic                          last_step,
  output euclid_ctrl_pkg::line_state_t  state,
  output euclid_geom_pkg::pos_x_t       p0_x,
  output euclid_geom_pkg::pos_y_t       p0_y,
  output euclid_geom_pkg::pos_x_t       p1_x,
  output euclid_geom_pkg::pos_y_t       p1_y,
  output euclid_geom_pkg::color_t       line_color,
  output logic                          busy,
  output logic                          job_done
);

  euclid_ctrl_pkg::line_state_t next_state;
  logic                         accept;

  assign accept = job_start && (state == euclid_ctrl_pkg::LINE_IDLE);

  always_comb
  begin
    next_state = state;
    case (state)
      euclid_ctrl_pkg::LINE_IDLE:
      begin
        if (accept)
        begin
          next_state = euclid_ctrl_pkg::LINE_INIT;
        end
      end
      euclid_ctrl_pkg::LINE_INIT:
      begin
        next_state = euclid_ctrl_pkg::LINE_DRAW;  // Walker and error load here
      end
      euclid_ctrl_pkg::LINE_DRAW:
      begin
        if (last_step)
        begin
          next_state = euclid_ctrl_pkg::LINE_IDLE;
        end
      end
      default:
      begin
        next_state = euclid_ctrl_pkg::LINE_IDLE;
      end
    endcase
  end

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= euclid_ctrl_pkg::LINE_IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  // Job latch, the source may change its inputs after acceptance
  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      p0_x       <= '0;
      p0_y       <= '0;
      p1_x       <= '0;
      p1_y       <= '0;
      line_color <= '0;
    end
    else if (accept)
    begin
      p0_x       <= x0;
      p0_y       <= y0;
      p1_x       <= x1;
      p1_y       <= y1;
      line_color <= color;
    end
  end

  assign busy     = (state != euclid_ctrl_pkg::LINE_IDLE);
  assign job_done = (state == euclid_ctrl_pkg::LINE_DRAW) && last_step;  // Same cycle as last xfer

  // Done is a single pulse that closes the busy window
  a_done_ends_busy: assert property (@(posedge cr_intf) disable iff (!rst_n)
    job_done |-> busy ##1 !busy);

  // The walker may only see the end point while a line is drawn
  a_last_in_draw: assert property (@(posedge cr_intf) disable iff (!rst_n)
    last_step |-> (state == euclid_ctrl_pkg::LINE_DRAW));

endmodule

//--- bresenham_err.sv
//******************************
// Bresenham step decision.
// Points must be stable from
// init to the end of the line.
// Equal coordinates count as a
// negative direction
//******************************

`include "euclid_settings.svh"

module bresenham_err (
  input  logic                          cr_intf,
  input  logic                          rst_n,
  input  euclid_ctrl_pkg::line_state_t  state,
  input  euclid_geom_pkg::pos_x_t       p0_x,
  input  euclid_geom_pkg::pos_y_t       p0_y,
  input  euclid_geom_pkg::pos_x_t       p1_x,
  input  euclid_geom_pkg::pos_y_t       p1_y,
  input  logic                          step,
  output logic                          inc_x,
  output logic                          dec_x,
  output logic                          inc_y,
  output logic                          dec_y
);

  logic                    sx;
  logic                    sy;
  euclid_geom_pkg::delta_t dx;
  euclid_geom_pkg::delta_t dy;
  euclid_geom_pkg::err_t   dx_s;
  euclid_geom_pkg::err_t   dy_s;
  euclid_geom_pkg::err_t   err;
  euclid_geom_pkg::err_t   err_next;

  logic signed [`EUCLID_IDX_W+1:0] e2;           // Twice the error
  logic signed [`EUCLID_IDX_W+1:0] e2_plus_dy;
  logic signed [`EUCLID_IDX_W+1:0] e2_minus_dx;
  logic                            x_move;
  logic                            y_move;

  // Directions toward the second point
  assign sx = (p1_x > p0_x);
  assign sy = (p1_y > p0_y);

  // Absolute deltas
  assign dx = sx ? euclid_geom_pkg::delta_t'(p1_x) - euclid_geom_pkg::delta_t'(p0_x)
                 : euclid_geom_pkg::delta_t'(p0_x) - euclid_geom_pkg::delta_t'(p1_x);
  assign dy = sy ? euclid_geom_pkg::delta_t'(p1_y) - euclid_geom_pkg::delta_t'(p0_y)
                 : euclid_geom_pkg::delta_t'(p0_y) - euclid_geom_pkg::delta_t'(p1_y);

  assign dx_s = euclid_geom_pkg::err_t'({1'b0, dx});
  assign dy_s = euclid_geom_pkg::err_t'({1'b0, dy});

  // Error stays within [-3dy/2, 3dx/2], so e2 plus or minus a delta fits one extra bit
  assign e2          = $signed({err, 1'b0});
  assign e2_plus_dy  = e2 + $signed({2'b00, dy});
  assign e2_minus_dx = e2 - $signed({2'b00, dx});

  // Only the two sign bits decide the step
  assign x_move = ~e2_plus_dy[`EUCLID_IDX_W+1];
  assign y_move = e2_minus_dx[`EUCLID_IDX_W+1];

  always_comb
  begin
    err_next = err;
    if (x_move)
    begin
      err_next = err_next - dy_s;
    end
    if (y_move)
    begin
      err_next = err_next + dx_s;
    end
  end

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      err <= '0;
    end
    else if (state == euclid_ctrl_pkg::LINE_INIT)
    begin
      err <= dx_s - dy_s;                         // err = dx - dy
    end
    else if ((state == euclid_ctrl_pkg::LINE_DRAW) && step)
    begin
      err <= err_next;
    end
  end

  assign inc_x = x_move & sx;
  assign dec_x = x_move & ~sx;
  assign inc_y = y_move & sy;
  assign dec_y = y_move & ~sy;

  // Each transfer moves at least one axis
  a_step_moves: assert property (@(posedge cr_intf) disable iff (!rst_n)
    ((state == euclid_ctrl_pkg::LINE_DRAW) && step) |-> (x_move || y_move));

endmodule

//--- pixel_walker.sv
//******************************
// Pixel output stage. Valid is
// a level held until the sink
// takes the pixel. End of line
// is found only here
//******************************

`include "euclid_settings.svh"

module pixel_walker (
  input  logic                          cr_intf,
  input  logic                          rst_n,
  input  euclid_ctrl_pkg::line_state_t  state,
  input  euclid_geom_pkg::pos_x_t       p0_x,
  input  euclid_geom_pkg::pos_y_t       p0_y,
  input  euclid_geom_pkg::pos_x_t       p1_x,
  input  euclid_geom_pkg::pos_y_t       p1_y,
  input  euclid_geom_pkg::color_t       line_color,
  input  logic                          inc_x,
  input  logic                          dec_x,
  input  logic                          inc_y,
  input  logic                          dec_y,
  input  logic                          pxl_ready,
  output logic                          pxl_valid,
  output euclid_geom_pkg::pos_x_t       pxl_x,
  output euclid_geom_pkg::pos_y_t       pxl_y,
  output euclid_geom_pkg::color_t       pxl_color,
  output logic                          step,
  output logic                          last_step
);

  logic at_end;

  assign step      = pxl_valid & pxl_ready;        // One pixel transferred
  assign at_end    = (pxl_x == p1_x) && (pxl_y == p1_y);
  assign last_step = step & at_end;

  always_ff @(posedge cr_intf or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pxl_valid <= 1'b0;
      pxl_x     <= '0;
      pxl_y     <= '0;
      pxl_color <= '0;
    end
    else
    begin
      case (state)
        euclid_ctrl_pkg::LINE_INIT:
        begin
          pxl_valid <= 1'b1;                       // First point goes out
          pxl_x     <= p0_x;
          pxl_y     <= p0_y;
          pxl_color <= line_color;
        end
        euclid_ctrl_pkg::LINE_DRAW:
        begin
          if (last_step)
          begin
            pxl_valid <= 1'b0;
          end
          else if (step)
          begin
            if (inc_x)
            begin
              pxl_x <= pxl_x + 1'b1;
            end
            else if (dec_x)
            begin
              pxl_x <= pxl_x - 1'b1;
            end
            if (inc_y)
            begin
              pxl_y <= pxl_y + 1'b1;
            end
            else if (dec_y)
            begin
              pxl_y <= pxl_y - 1'b1;
            end
          end
        end
        default:
        begin
          pxl_valid <= 1'b0;                       // Position and color hold
        end
      endcase
    end
  end

  // Back-pressure keeps the offered pixel intact
  a_hold_on_stall: assert property (@(posedge cr_intf) disable iff (!rst_n)
    (pxl_valid && !pxl_ready) |=> $stable(pxl_x) && $stable(pxl_y) && $stable(pxl_color));

endmodule

//--- euclid_line_top.sv
//******************************
// Line rasterizer top. Start is
// a one-cycle pulse, the pixel
// side is valid with ready.
// Latency depends on length and
// back-pressure
//******************************

`include "euclid_settings.svh"

module euclid_line_top (
  input  logic                     cr_intf,
  input  logic                     rst_n,
  input  logic                     job_start,
  input  euclid_geom_pkg::pos_x_t  x0,
  input  euclid_geom_pkg::pos_y_t  y0,
  input  euclid_geom_pkg::pos_x_t  x1,
  input  euclid_geom_pkg::pos_y_t  y1,
  input  euclid_geom_pkg::color_t  color,
  output logic                     busy,
  output logic                     job_done,
  output logic                     pxl_valid,
  output euclid_geom_pkg::pos_x_t  pxl_x,
  output euclid_geom_pkg::pos_y_t  pxl_y,
  output euclid_geom_pkg::color_t  pxl_color,
  input  logic                     pxl_ready
);

  euclid_ctrl_pkg::line_state_t state;
  euclid_geom_pkg::pos_x_t      p0_x;
  euclid_geom_pkg::pos_y_t      p0_y;
  euclid_geom_pkg::pos_x_t      p1_x;
  euclid_geom_pkg::pos_y_t      p1_y;
  euclid_geom_pkg::color_t      line_color;
  logic                         inc_x;
  logic                         dec_x;
  logic                         inc_y;
  logic                         dec_y;
  logic                         step;
  logic                         last_step;

  line_job_ctrl i_line_job_ctrl (
    .cr_intf    (cr_intf),
    .rst_n      (rst_n),
    .job_start  (job_start),
    .x0         (x0),
    .y0         (y0),
    .x1         (x1),
    .y1         (y1),
    .color      (color),
    .last_step  (last_step),
    .state      (state),
    .p0_x       (p0_x),
    .p0_y       (p0_y),
    .p1_x       (p1_x),
    .p1_y       (p1_y),
    .line_color (line_color),
    .busy       (busy),
    .job_done   (job_done)
  );

  bresenham_err i_bresenham_err (
    .cr_intf (cr_intf),
    .rst_n   (rst_n),
    .state   (state),
    .p0_x    (p0_x),
    .p0_y    (p0_y),
    .p1_x    (p1_x),
    .p1_y    (p1_y),
    .step    (step),
    .inc_x   (inc_x),
    .dec_x   (dec_x),
    .inc_y   (inc_y),
    .dec_y   (dec_y)
  );

  pixel_walker i_pixel_walker (
    .cr_intf    (cr_intf),
    .rst_n      (rst_n),
    .state      (state),
    .p0_x       (p0_x),
    .p0_y       (p0_y),
    .p1_x       (p1_x),
    .p1_y       (p1_y),
    .line_color (line_color),
    .inc_x      (inc_x),
    .dec_x      (dec_x),
    .inc_y      (inc_y),
    .dec_y      (dec_y),
    .pxl_ready  (pxl_ready),
    .pxl_valid  (pxl_valid),
    .pxl_x      (pxl_x),
    .pxl_y      (pxl_y),
    .pxl_color  (pxl_color),
    .step       (step),
    .last_step  (last_step)
  );

endmodule

//--- tb_euclid_line.sv
//******************************
// Testbench for the line core.
// Inputs change on the falling
// edge, outputs are sampled on
// the rising edge. Every wait
// has its own cycle limit
//******************************

`include "euclid_settings.svh"

module tb_euclid_line;

  localparam int JOB_TIMEOUT = 20000;   // Cycles allowed per job
  localparam int YW          = `EUCLID_Y_W;
  localparam int PW          = `EUCLID_X_W + `EUCLID_Y_W;

  logic                    cr_intf;
  logic                    rst_n;
  logic                    job_start;
  euclid_geom_pkg::pos_x_t x0;
  euclid_geom_pkg::pos_y_t y0;
  euclid_geom_pkg::pos_x_t x1;
  euclid_geom_pkg::pos_y_t y1;
  euclid_geom_pkg::color_t color;
  logic                    busy;
  logic                    job_done;
  logic                    pxl_valid;
  euclid_geom_pkg::pos_x_t pxl_x;
  euclid_geom_pkg::pos_y_t pxl_y;
  euclid_geom_pkg::color_t pxl_color;
  logic                    pxl_ready;

  integer                  seed;
  string                   test_name;
  logic [PW-1:0]           exp_q[$];     // Expected pixels as {x, y}
  logic [PW-1:0]           exp_pix;
  euclid_geom_pkg::color_t exp_color;
  int                      done_cnt;
  int                      xfer_cnt;
  int                      total_exp;
  logic                    stall_seen;
  logic                    done_seen;
  logic                    xfer;
  logic                    last_expected;
  euclid_geom_pkg::pos_x_t held_x;
  euclid_geom_pkg::pos_y_t held_y;
  euclid_geom_pkg::color_t held_color;

  euclid_line_top i_euclid_line_top (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .job_start (job_start),
    .x0        (x0),
    .y0        (y0),
    .x1        (x1),
    .y1        (y1),
    .color     (color),
    .busy      (busy),
    .job_done  (job_done),
    .pxl_valid (pxl_valid),
    .pxl_x     (pxl_x),
    .pxl_y     (pxl_y),
    .pxl_color (pxl_color),
    .pxl_ready (pxl_ready)
  );

  always #50 cr_intf = ~cr_intf;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_pos(input string name,
                           input euclid_geom_pkg::pos_x_t exp_x,
                           input euclid_geom_pkg::pos_y_t exp_y,
                           input euclid_geom_pkg::pos_x_t act_x,
                           input euclid_geom_pkg::pos_y_t act_y);
    if ((exp_x !== act_x) || (exp_y !== act_y))
    begin
      abort_run($sformatf("[FAIL] %s expected (%0d,%0d) actual (%0d,%0d)",
                          name, exp_x, exp_y, act_x, act_y));
    end
  endtask

  task automatic check_color(input string name, input euclid_geom_pkg::color_t exp_c,
                             input euclid_geom_pkg::color_t act_c);
    if (exp_c !== act_c)
    begin
      abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp_c, act_c));
    end
  endtask

  task automatic check_flag(input string name, input logic exp_f, input logic act_f);
    if (exp_f !== act_f)
    begin
      abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp_f, act_f));
    end
  endtask

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // Reference Bresenham walk from the first point to the second
  // e2 holds twice the error
  function automatic void build_expected_pixels(input int ax, input int ay,
                                                input int bx, input int by);
    int dx;
    int dy;
    int sx;
    int sy;
    int err;
    int e2;
    int x;
    int y;
    dx  = (bx > ax) ? bx - ax : ax - bx;
    dy  = (by > ay) ? by - ay : ay - by;
    sx  = (bx > ax) ? 1 : -1;
    sy  = (by > ay) ? 1 : -1;
    err = dx - dy;
    x   = ax;
    y   = ay;
    for (int n = 0; n < 4096; n++)
    begin
      exp_q.push_back({x[`EUCLID_X_W-1:0], y[`EUCLID_Y_W-1:0]});
      total_exp++;
      if ((x == bx) && (y == by))
      begin
        break;
      end
      e2 = 2 * err;
      if (e2 + dy >= 0)
      begin
        err = err - dy;
        x   = x + sx;
      end
      if (e2 < dx)
      begin
        err = err + dx;
        y   = y + sy;
      end
    end
  endfunction

  // Pops one expected pixel per transfer
  always @(posedge cr_intf)
  begin
    if (rst_n)
    begin
      if (stall_seen)
      begin
        check_pos({test_name, " stall position"}, held_x, held_y, pxl_x, pxl_y);
        check_color({test_name, " stall color"}, held_color, pxl_color);
      end
      if (done_seen)
      begin
        check_flag({test_name, " busy after done"}, 1'b0, busy);
        check_flag({test_name, " pxl_valid after done"}, 1'b0, pxl_valid);
      end
      if (pxl_valid)
      begin
        check_flag({test_name, " busy with pxl_valid"}, 1'b1, busy);
      end
      xfer          = pxl_valid && pxl_ready;
      last_expected = 1'b0;
      if (xfer)
      begin
        if (exp_q.size() == 0)
        begin
          abort_run($sformatf("%s: pixel (%0d,%0d) was sent after the end of the line",
                              test_name, pxl_x, pxl_y));
        end
        else
        begin
          exp_pix = exp_q.pop_front();
          check_pos({test_name, " pixel"}, exp_pix[PW-1:YW], exp_pix[YW-1:0], pxl_x, pxl_y);
          check_color({test_name, " color"}, exp_color, pxl_color);
          last_expected = (exp_q.size() == 0);   // Done only with the last pixel
          xfer_cnt++;
        end
      end
      check_flag({test_name, " job_done"}, last_expected, job_done);
      stall_seen = pxl_valid && !pxl_ready;
      held_x     = pxl_x;
      held_y     = pxl_y;
      held_color = pxl_color;
      done_seen  = job_done;
      if (job_done)
      begin
        done_cnt++;
      end
    end
  end

  // Runs one job and disturbs the inputs after acceptance
  task automatic run_line(input string name,
                          input euclid_geom_pkg::pos_x_t ax, input euclid_geom_pkg::pos_y_t ay,
                          input euclid_geom_pkg::pos_x_t bx, input euclid_geom_pkg::pos_y_t by,
                          input euclid_geom_pkg::color_t c, input bit rnd_ready);
    int done_mark;
    int cyc;
    @(negedge cr_intf);
    test_name = name;
    exp_color = c;
    build_expected_pixels(ax, ay, bx, by);
    x0        = ax;
    y0        = ay;
    x1        = bx;
    y1        = by;
    color     = c;
    job_start = 1'b1;
    pxl_ready = rnd_ready ? (rand_below(4) != 0) : 1'b1;
    done_mark = done_cnt;
    cyc       = 0;
    while (done_cnt == done_mark)
    begin
      @(negedge cr_intf);
      cyc++;
      if (cyc > JOB_TIMEOUT)
      begin
        abort_run($sformatf("%s: job_done did not arrive within %0d cycles",
                            name, JOB_TIMEOUT));
      end
      job_start = (cyc == 2);             // Second start lands while busy
      if (cyc == 1)
      begin
        x0    = x0 + 10'd7;
        y0    = y0 + 10'd3;
        x1    = x1 - 10'd5;
        color = ~color;
      end
      pxl_ready = rnd_ready ? (rand_below(4) != 0) : 1'b1;
    end
    job_start = 1'b0;
    if (exp_q.size() != 0)
    begin
      abort_run($sformatf("%s: %0d pixels of the line were never sent", name, exp_q.size()));
    end
  endtask

  initial
  begin
    int oct;
    int major;
    int minor;
    int ddx;
    int ddy;
    int ax;
    int ay;
    seed       = 47716;
    cr_intf    = 1'b0;
    rst_n      = 1'b0;
    job_start  = 1'b0;
    x0         = '0;
    y0         = '0;
    x1         = '0;
    y1         = '0;
    color      = '0;
    pxl_ready  = 1'b0;
    test_name  = "reset";
    exp_color  = '0;
    done_cnt   = 0;
    xfer_cnt   = 0;
    total_exp  = 0;
    stall_seen = 1'b0;
    done_seen  = 1'b0;
    repeat (3) @(negedge cr_intf);
    rst_n = 1'b1;
    @(negedge cr_intf);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset job_done", 1'b0, job_done);
    check_flag("reset pxl_valid", 1'b0, pxl_valid);
    check_pos("reset position", '0, '0, pxl_x, pxl_y);
    check_color("reset color", '0, pxl_color);

    run_line("horizontal", 10'd10, 10'd20, 10'd40, 10'd20, 24'h11aa33, 1'b0);
    run_line("horizontal_left", 10'd300, 10'd5, 10'd270, 10'd5, 24'h804020, 1'b0);
    run_line("vertical", 10'd64, 10'd100, 10'd64, 10'd130, 24'h00ff00, 1'b0);
    run_line("vertical_up", 10'd900, 10'd600, 10'd900, 10'd577, 24'h0000ff, 1'b0);
    run_line("diagonal", 10'd0, 10'd0, 10'd25, 10'd25, 24'hc0ffee, 1'b0);
    run_line("anti_diagonal", 10'd500, 10'd200, 10'd480, 10'd220, 24'h123456, 1'b0);
    run_line("single_point", 10'd777, 10'd333, 10'd777, 10'd333, 24'hfedcba, 1'b0);

    // Bit 0 of the octant flips x, bit 1 flips y and bit 2 makes y the major axis
    for (int i = 0; i < 32; i++)
    begin
      oct   = i % 8;
      major = 1 + rand_below(60);
      minor = rand_below(major + 1);
      ddx   = oct[2] ? minor : major;
      ddy   = oct[2] ? major : minor;
      if (oct[0])
      begin
        ddx = -ddx;
      end
      if (oct[1])
      begin
        ddy = -ddy;
      end
      ax = 100 + rand_below(800);
      ay = 100 + rand_below(800);
      run_line($sformatf("random_%0d_octant_%0d", i, oct),
               euclid_geom_pkg::pos_x_t'(ax), euclid_geom_pkg::pos_y_t'(ay),
               euclid_geom_pkg::pos_x_t'(ax + ddx), euclid_geom_pkg::pos_y_t'(ay + ddy),
               euclid_geom_pkg::color_t'($random(seed)), 1'b1);
    end

    repeat (3) @(negedge cr_intf);
    if ((xfer_cnt == total_exp) && (done_cnt == 39) && !busy)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      abort_run($sformatf("Run ended with %0d of %0d pixels and %0d of 39 jobs done",
                          xfer_cnt, total_exp, done_cnt));
    end
  end

endmodule

//--- vlog.f
+incdir+.
euclid_geom_pkg.sv
euclid_ctrl_pkg.sv
line_job_ctrl.sv
bresenham_err.sv
pixel_walker.sv
euclid_line_top.sv
tb_euclid_line.sv

//--- run.sh
#!/bin/sh
# Builds the line rasterizer testbench with Verilator and runs it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_euclid_line -f vlog.f -o tb_euclid_line
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit $status
fi

./obj_dir/tb_euclid_line
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
